// File: logic/lpBusDecode.sv
// AXI4-Lite front end
module lpBusDecode import lpPkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   // Write address and data channels
   input  logic [addrWidth-1:0] awaddr,
   input  logic                 awvalid,
   output logic                 awready,
   input  logic [busWidth-1:0]  wdata,
   input  logic [3:0]           wstrb,
   input  logic                 wvalid,
   output logic                 wready,
   // Write response channel
   output axiRespT              bresp,
   output logic                 bvalid,
   input  logic                 bready,
   // Read address channel
   input  logic [addrWidth-1:0] araddr,
   input  logic                 arvalid,
   output logic                 arready,
   // Read data state, only for gating
   input  logic                 rvalid,
   input  logic                 rready,
   // Register side
   output logic                 csraWrite,
   output logic                 csrbWrite,
   output logic                 loByte,
   output logic                 hiByte,
   output logic [regWidth-1:0]  writeData,
   output logic                 readAccept,
   output regSelT               readSel
);

   logic   writeAccept;
   logic   writeFree;
   logic   readFree;
   regSelT writeSel;

   ////////////////////
   // Address decode
   ////////////////////

   // Exact word match, anything else is unmapped
   function automatic regSelT decodeAddr(input logic [addrWidth-1:0] addr);
      regSelT sel;
      if (addr == csraAddr)
         sel = selCsra;
      else if (addr == csrbAddr)
         sel = selCsrb;
      else
         sel = selNone;
      return sel;
   endfunction

   assign writeSel = decodeAddr(awaddr);
   assign readSel  = decodeAddr(araddr);

   ////////////////////
   // Write channel
   ////////////////////

   // Slot is free when no response is held or it retires this cycle
   assign writeFree   = ~bvalid | bready;
   // Address and data must arrive together
   assign writeAccept = awvalid & wvalid & writeFree;

   // Both readies share the one accept cycle
   assign awready = writeAccept;
   assign wready  = writeAccept;

   // Strobes land in the register on the handshake edge
   assign csraWrite = writeAccept & (writeSel == selCsra);
   assign csrbWrite = writeAccept & (writeSel == selCsrb);

   // Byte lanes 0 and 1 cover the 16-bit word
   assign loByte    = wstrb[0];
   assign hiByte    = wstrb[1];
   assign writeData = wdata[regWidth-1:0];

   // Response valid one cycle after the handshake
   always_ff @(posedge clk)
   begin
      if (rst)
         bvalid <= 1'b0;
      else if (writeAccept)
         bvalid <= 1'b1;
      else if (bready)
         bvalid <= 1'b0;
   end

   // Response code for the accepted write
   always_ff @(posedge clk)
   begin
      if (writeAccept)
      begin
         if (writeSel == selNone)
            bresp <= respSlvErr;
         else
            bresp <= respOkay;
      end
   end

   ////////////////////
   // Read channel
   ////////////////////

   // One accept per free read slot
   assign readFree   = ~rvalid | rready;
   assign readAccept = arvalid & readFree;
   assign arready    = readAccept;

endmodule

// File: logic/lpCsra.sv
// Control and status register A
module lpCsra import lpPkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  logic                csraWrite,
   input  logic                loByte,
   input  logic                hiByte,
   input  logic [regWidth-1:0] writeData,
   input  logic                printDone,
   input  logic                online,
   input  logic                errSummary,
   output logic                lpInit,
   output logic                lpEclr,
   output logic                goErrSet,
   output logic [regWidth-1:0] regCsra,
   output logic                irq
);

   logic      goReg;
   printModeT modeReg;
   logic      ieReg;
   logic      doneReg;
   logic      loWrite;
   logic      hiWrite;
   logic      goWrite;

   // Per-lane write enables
   assign loWrite = csraWrite & loByte;
   assign hiWrite = csraWrite & hiByte;
   // GO written as one
   assign goWrite = loWrite & writeData[csraGo];

   ////////////////////
   // Command pulses
   ////////////////////

   // Initialize and error clear live only on the write edge
   assign lpInit = hiWrite & writeData[csraInit];
   assign lpEclr = hiWrite & writeData[csraEclr];

   // Starting while offline is a GO error
   assign goErrSet = goWrite & ~online;

   ////////////////////
   // Low byte state
   ////////////////////

   // GO bit
   // A write wins over printDone, init wins over both
   always_ff @(posedge clk)
   begin
      if (rst | lpInit)
         goReg <= 1'b0;
      else if (loWrite)
         goReg <= writeData[csraGo];
      else if (printDone)
         goReg <= 1'b0;
   end

   // Mode and interrupt enable
   always_ff @(posedge clk)
   begin
      if (rst | lpInit)
      begin
         modeReg <= modePrint;
         ieReg   <= 1'b0;
      end
      else if (loWrite)
      begin
         modeReg <= printModeT'(writeData[csraModeLo +: 2]);
         ieReg   <= writeData[csraIe];
      end
   end

   // DONE flag, cleared by a new GO
   always_ff @(posedge clk)
   begin
      if (rst)
         doneReg <= 1'b0;
      else if (goWrite)
         doneReg <= 1'b0;
      else if (printDone)
         doneReg <= 1'b1;
   end

   ////////////////////
   // Register image
   ////////////////////

   always_comb
   begin
      regCsra                  = '0;
      regCsra[csraGo]          = goReg;
      regCsra[csraModeLo +: 2] = modeReg;
      regCsra[csraIe]          = ieReg;
      regCsra[csraDone]        = doneReg;
      // Command bits are write-only
      regCsra[csraEclr]        = 1'b0;
      regCsra[csraInit]        = 1'b0;
      regCsra[csraErr]         = errSummary;
   end

   // Interrupt on done or any error when enabled
   assign irq = ieReg & (doneReg | errSummary);

endmodule

// File: logic/lpCsrb.sv
// Control and status register B
module lpCsrb import lpPkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  logic                csrbWrite,
   input  logic                hiByte,
   input  logic [regWidth-1:0] writeData,
   input  logic                lpInit,
   input  logic                lpEclr,
   input  logic                goErrSet,
   // Live printer status
   input  logic                printVal,
   input  logic                printDpar,
   input  logic                ovfu,
   input  logic                online,
   input  logic                vfuRdy,
   input  logic                printLpe,
   // Error events
   input  logic                setMpe,
   input  logic                setRpe,
   input  logic                setMsyn,
   input  logic                setDte,
   output logic [regWidth-1:0] regCsrb,
   output logic                errSummary
);

   logic [2:0] testReg;
   logic       mpeReg;
   logic       rpeReg;
   logic       goeReg;
   logic       msynReg;
   logic       dteReg;
   logic       vfuErr;

   // DAVFU error is simply not ready
   assign vfuErr = ~vfuRdy;

   ////////////////////
   // Init-cleared state
   ////////////////////

   // TEST field takes the high byte only
   always_ff @(posedge clk)
   begin
      if (rst | lpInit)
         testReg <= '0;
      else if (csrbWrite & hiByte)
         testReg <= writeData[csrbTestLo +: 3];
   end

   // Parity and GO errors stay set until init
   always_ff @(posedge clk)
   begin
      if (rst | lpInit)
      begin
         mpeReg <= 1'b0;
         rpeReg <= 1'b0;
         goeReg <= 1'b0;
      end
      else
      begin
         if (setMpe)
            mpeReg <= 1'b1;
         if (setRpe)
            rpeReg <= 1'b1;
         if (goErrSet)
            goeReg <= 1'b1;
      end
   end

   ////////////////////
   // Eclr-cleared state
   ////////////////////

   // Bus timeout and demand timeout
   always_ff @(posedge clk)
   begin
      if (rst | lpEclr)
      begin
         msynReg <= 1'b0;
         dteReg  <= 1'b0;
      end
      else
      begin
         if (setMsyn)
            msynReg <= 1'b1;
         if (setDte)
            dteReg <= 1'b1;
      end
   end

   // Feeds ERR in CSRA
   assign errSummary = goeReg | dteReg | msynReg | rpeReg | mpeReg | printLpe | vfuErr;

   ////////////////////
   // Register image
   ////////////////////

   always_comb
   begin
      regCsrb                  = '0;
      regCsrb[csrbGoe]         = goeReg;
      regCsrb[csrbDte]         = dteReg;
      regCsrb[csrbMsyn]        = msynReg;
      regCsrb[csrbRpe]         = rpeReg;
      regCsrb[csrbMpe]         = mpeReg;
      regCsrb[csrbLpe]         = printLpe;
      regCsrb[csrbVfue]        = vfuErr;
      regCsrb[csrbOffline]     = ~online;
      regCsrb[csrbTestLo +: 3] = testReg;
      regCsrb[csrbOvfu]        = ovfu;
      regCsrb[csrbDpar]        = printDpar;
      // Printer not ready is never reported
      regCsrb[csrbNrdy]        = 1'b0;
      // bit 14 stays zero
      regCsrb[csrbVal]         = printVal;
   end

endmodule

// File: logic/lpPkg.sv
// Line printer register definitions
package lpPkg;

   ////////////////////
   // Widths
   ////////////////////

   // Both CSRs are one PDP-11 word
   localparam int regWidth  = 16;
   localparam int busWidth  = 32;
   localparam int addrWidth = 4;

   // Byte offsets on the AXI side
   localparam logic [addrWidth-1:0] csraAddr = 4'h0;
   localparam logic [addrWidth-1:0] csrbAddr = 4'h4;

   ////////////////////
   // CSRA layout
   ////////////////////

   localparam int csraGo     = 0;
   // Two-bit mode field starts here
   localparam int csraModeLo = 2;
   localparam int csraIe     = 6;
   localparam int csraDone   = 7;
   localparam int csraEclr   = 12;
   localparam int csraInit   = 14;
   localparam int csraErr    = 15;

   ////////////////////
   // CSRB layout
   ////////////////////

   localparam int csrbGoe     = 0;
   localparam int csrbDte     = 1;
   localparam int csrbMsyn    = 2;
   localparam int csrbRpe     = 3;
   localparam int csrbMpe     = 4;
   localparam int csrbLpe     = 5;
   localparam int csrbVfue    = 6;
   localparam int csrbOffline = 7;
   // Three-bit test field starts here
   localparam int csrbTestLo  = 8;
   localparam int csrbOvfu    = 11;
   localparam int csrbDpar    = 12;
   localparam int csrbNrdy    = 13;
   localparam int csrbVal     = 15;

   ////////////////////
   // Enums
   ////////////////////

   // Decoded register target
   typedef enum logic [1:0] {selCsra, selCsrb, selNone} regSelT;

   // CSRA mode field encoding
   typedef enum logic [1:0] {modePrint, modeTest, modeLoadRam, modeLoadVfu} printModeT;

   // AXI response codes in use
   typedef enum logic [1:0] {respOkay = 2'd0, respSlvErr = 2'd2} axiRespT;

endpackage

// File: logic/lpReadMux.sv
// Read data path
module lpReadMux import lpPkg::*;
(
   input  logic                clk,
   input  logic                rst,
   input  logic                readAccept,
   input  regSelT              readSel,
   input  logic [regWidth-1:0] regCsra,
   input  logic [regWidth-1:0] regCsrb,
   output logic [busWidth-1:0] rdata,
   output axiRespT             rresp,
   output logic                rvalid,
   input  logic                rready
);

   ////////////////////
   // Read data capture
   ////////////////////

   // Sample on the address handshake edge
   always_ff @(posedge clk)
   begin
      if (readAccept)
      begin
         case (readSel)
            selCsra:
            begin
               rdata <= busWidth'(regCsra);
               rresp <= respOkay;
            end
            selCsrb:
            begin
               rdata <= busWidth'(regCsrb);
               rresp <= respOkay;
            end
            default:
            begin
               // Unmapped, zero with slave error
               rdata <= '0;
               rresp <= respSlvErr;
            end
         endcase
      end
   end

   // Valid held until the master takes it
   always_ff @(posedge clk)
   begin
      if (rst)
         rvalid <= 1'b0;
      else if (readAccept)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

endmodule

// File: logic/lpRegs.sv
// Line printer register block
module lpRegs import lpPkg::*;
(
   input  logic                 clk,
   input  logic                 rst,
   // AXI4-Lite slave
   input  logic [addrWidth-1:0] awaddr,
   input  logic                 awvalid,
   output logic                 awready,
   input  logic [busWidth-1:0]  wdata,
   input  logic [3:0]           wstrb,
   input  logic                 wvalid,
   output logic                 wready,
   output axiRespT              bresp,
   output logic                 bvalid,
   input  logic                 bready,
   input  logic [addrWidth-1:0] araddr,
   input  logic                 arvalid,
   output logic                 arready,
   output logic [busWidth-1:0]  rdata,
   output axiRespT              rresp,
   output logic                 rvalid,
   input  logic                 rready,
   // Printer side
   input  logic                 printDone,
   input  logic                 online,
   input  logic                 vfuRdy,
   input  logic                 ovfu,
   input  logic                 printVal,
   input  logic                 printLpe,
   input  logic                 printDpar,
   input  logic                 setMpe,
   input  logic                 setRpe,
   input  logic                 setMsyn,
   input  logic                 setDte,
   output logic                 irq
);

   // Decode to registers
   logic                csraWrite;
   logic                csrbWrite;
   logic                loByte;
   logic                hiByte;
   logic [regWidth-1:0] writeData;
   logic                readAccept;
   regSelT              readSel;
   // Between the two CSRs
   logic                lpInit;
   logic                lpEclr;
   logic                goErrSet;
   logic                errSummary;
   // Register images
   logic [regWidth-1:0] regCsra;
   logic [regWidth-1:0] regCsrb;

   lpBusDecode busDecode (
      .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rvalid, .rready,
      .csraWrite, .csrbWrite, .loByte, .hiByte, .writeData, .readAccept, .readSel
   );

   lpCsra csra (
      .clk, .rst, .csraWrite, .loByte, .hiByte, .writeData, .printDone, .online,
      .errSummary, .lpInit, .lpEclr, .goErrSet, .regCsra, .irq
   );

   lpCsrb csrb (
      .clk, .rst, .csrbWrite, .hiByte, .writeData, .lpInit, .lpEclr, .goErrSet,
      .printVal, .printDpar, .ovfu, .online, .vfuRdy, .printLpe,
      .setMpe, .setRpe, .setMsyn, .setDte, .regCsrb, .errSummary
   );

   lpReadMux readMux (
      .clk, .rst, .readAccept, .readSel, .regCsra, .regCsrb,
      .rdata, .rresp, .rvalid, .rready
   );

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the line printer register testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -f src.f --top-module lpRegsTb -o simv > build.log 2>&1 \
   || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1
grep -q "Simulation finished: FAIL" sim.log \
   && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "Simulation finished: PASS" sim.log \
   || { echo "Simulation ended without a result, see sim.log"; exit 1; }
echo "Simulation passed"

// File: src.f
logic/lpPkg.sv
logic/lpBusDecode.sv
logic/lpCsra.sv
logic/lpCsrb.sv
logic/lpReadMux.sv
logic/lpRegs.sv
verification/lpRegsTb.sv

// File: verification/lpRegsTb.sv
// Line printer register testbench
module lpRegsTb import lpPkg::*;
();

   // Well above the length of all tests together
   localparam int timeoutCycles = 4000;

   logic                 clk = 1'b0;
   logic                 rst;
   logic [addrWidth-1:0] awaddr;
   logic                 awvalid;
   logic                 awready;
   logic [busWidth-1:0]  wdata;
   logic [3:0]           wstrb;
   logic                 wvalid;
   logic                 wready;
   axiRespT              bresp;
   logic                 bvalid;
   logic                 bready;
   logic [addrWidth-1:0] araddr;
   logic                 arvalid;
   logic                 arready;
   logic [busWidth-1:0]  rdata;
   axiRespT              rresp;
   logic                 rvalid;
   logic                 rready;
   logic                 printDone;
   logic                 online;
   logic                 vfuRdy;
   logic                 ovfu;
   logic                 printVal;
   logic                 printLpe;
   logic                 printDpar;
   logic                 setMpe;
   logic                 setRpe;
   logic                 setMsyn;
   logic                 setDte;
   logic                 irq;

   // Shadow model of the register state
   logic       goModel;
   logic [1:0] modeModel;
   logic       ieModel;
   logic       doneModel;
   logic [2:0] testModel;
   logic       mpeModel;
   logic       rpeModel;
   logic       goeModel;
   logic       msynModel;
   logic       dteModel;

   int cycleCount = 0;

   always #20 clk = ~clk;

   lpRegs uut (
      .clk, .rst, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
      .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
      .rvalid, .rready, .printDone, .online, .vfuRdy, .ovfu, .printVal, .printLpe,
      .printDpar, .setMpe, .setRpe, .setMsyn, .setDte, .irq
   );

   ////////////////////
   // Reference model
   ////////////////////

   // Error summary, latched errors plus live LPE and VFU not ready
   function automatic logic errModel();
      return goeModel | dteModel | msynModel | rpeModel | mpeModel | printLpe | ~vfuRdy;
   endfunction

   // Expected register image, zero for an unmapped address
   function automatic logic [15:0] expectReg(input logic [3:0] addr);
      logic [15:0] val;
      val = '0;
      if (addr == 4'h0)
      begin
         val[0]   = goModel;
         val[3:2] = modeModel;
         val[6]   = ieModel;
         val[7]   = doneModel;
         // ECLR and INIT always read as zero
         val[15]  = errModel();
      end
      else if (addr == 4'h4)
      begin
         val[0]    = goeModel;
         val[1]    = dteModel;
         val[2]    = msynModel;
         val[3]    = rpeModel;
         val[4]    = mpeModel;
         val[5]    = printLpe;
         val[6]    = ~vfuRdy;
         val[7]    = ~online;
         val[10:8] = testModel;
         val[11]   = ovfu;
         val[12]   = printDpar;
         // NRDY and bit 14 stay zero
         val[15]   = printVal;
      end
      return val;
   endfunction

   // Model update on the write handshake edge
   function automatic void applyWrite(input logic [3:0] addr, input logic [15:0] data,
                                      input logic [3:0] strb);
      if (addr == 4'h0)
      begin
         if (strb[0])
         begin
            // GO as one clears DONE, offline start is a GO error
            if (data[0])
            begin
               doneModel = 1'b0;
               if (!online)
                  goeModel = 1'b1;
            end
            goModel   = data[0];
            modeModel = data[3:2];
            ieModel   = data[6];
         end
         // Error clear
         if (strb[1] && data[12])
         begin
            msynModel = 1'b0;
            dteModel  = 1'b0;
         end
         // Init wins over the low byte
         if (strb[1] && data[14])
         begin
            goModel   = 1'b0;
            modeModel = 2'b00;
            ieModel   = 1'b0;
            mpeModel  = 1'b0;
            rpeModel  = 1'b0;
            goeModel  = 1'b0;
            testModel = 3'b000;
         end
      end
      else if (addr == 4'h4 && strb[1])
         testModel = data[10:8];
   endfunction

   ////////////////////
   // Checking
   ////////////////////

   task automatic stopFail();
      $display("Simulation finished: FAIL");
      $fatal(1, "Stopping at the first failure");
   endtask

   task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                             input string name);
      if (actual !== expected)
      begin
         $display("** Error at %0t: %s is %h, expected %h", $time, name, actual, expected);
         stopFail();
      end
   endtask

   // irq follows IE and (DONE or ERR) every cycle
   always @(negedge clk)
   begin
      if (!rst)
         checkValue(32'(irq), 32'(ieModel & (doneModel | errModel())), "irq");
   end

   // Cycle limit
   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= timeoutCycles)
      begin
         $display("The run timed out after %0d cycles before the tests ended", cycleCount);
         stopFail();
      end
   end

   ////////////////////
   // Bus and printer tasks
   ////////////////////

   // Write with random bready delay, then response check
   task automatic axiWrite(input logic [3:0] addr, input logic [15:0] data,
                           input logic [3:0] strb);
      int      delay;
      axiRespT respExp;
      respExp = (addr == 4'h0 || addr == 4'h4) ? respOkay : respSlvErr;
      @(posedge clk);
      awaddr  <= addr;
      wdata   <= {16'($urandom), data};
      wstrb   <= strb;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      @(negedge clk);
      while (!awready)
         @(negedge clk);
      checkValue(32'(wready), 32'd1, "wready");
      @(posedge clk);
      // Register takes the write here
      applyWrite(addr, data, strb);
      @(negedge clk);
      checkValue(32'(bvalid), 32'd1, "bvalid one cycle after handshake");
      // Valids stay high, so a stalled slot must refuse them
      checkValue(32'(awready), 32'd0, "awready under back-pressure");
      delay = $urandom_range(3);
      repeat (delay)
      begin
         @(negedge clk);
         checkValue(32'(awready), 32'd0, "awready under back-pressure");
      end
      checkValue(32'(bresp), 32'(respExp), "bresp");
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      bready  <= 1'b1;
      @(posedge clk);
      bready  <= 1'b0;
   endtask

   // Read with random rready delay, data checked against the model
   task automatic axiRead(input logic [3:0] addr);
      int          delay;
      logic [31:0] dataExp;
      axiRespT     respExp;
      string       regName;
      respExp = (addr == 4'h0 || addr == 4'h4) ? respOkay : respSlvErr;
      regName = (addr == 4'h0) ? "CSRA" : ((addr == 4'h4) ? "CSRB" : "unmapped read");
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      @(negedge clk);
      while (!arready)
         @(negedge clk);
      // State seen by the sampling edge
      dataExp = 32'(expectReg(addr));
      @(posedge clk);
      @(negedge clk);
      checkValue(32'(rvalid), 32'd1, "rvalid one cycle after handshake");
      checkValue(32'(arready), 32'd0, "arready under back-pressure");
      delay = $urandom_range(3);
      repeat (delay)
      begin
         @(negedge clk);
         checkValue(32'(arready), 32'd0, "arready under back-pressure");
      end
      checkValue(rdata, dataExp, regName);
      checkValue(32'(rresp), 32'(respExp), "rresp");
      @(posedge clk);
      arvalid <= 1'b0;
      rready  <= 1'b1;
      @(posedge clk);
      rready  <= 1'b0;
   endtask

   // One-cycle printer event
   // 0 printDone, 1 MPE, 2 RPE, 3 MSYN, 4 DTE
   task automatic pulseEvent(input int which);
      @(posedge clk);
      case (which)
         0: printDone <= 1'b1;
         1: setMpe    <= 1'b1;
         2: setRpe    <= 1'b1;
         3: setMsyn   <= 1'b1;
         4: setDte    <= 1'b1;
         default: ;
      endcase
      @(posedge clk);
      printDone <= 1'b0;
      setMpe    <= 1'b0;
      setRpe    <= 1'b0;
      setMsyn   <= 1'b0;
      setDte    <= 1'b0;
      // DUT latches the event on this edge
      case (which)
         0:
         begin
            doneModel = 1'b1;
            goModel   = 1'b0;
         end
         1: mpeModel  = 1'b1;
         2: rpeModel  = 1'b1;
         3: msynModel = 1'b1;
         4: dteModel  = 1'b1;
         default: ;
      endcase
   endtask

   // Order is printVal, printDpar, ovfu, online, vfuRdy, printLpe
   task automatic driveStatus(input logic [5:0] bits);
      @(posedge clk);
      {printVal, printDpar, ovfu, online, vfuRdy, printLpe} <= bits;
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial
   begin
      void'($urandom(77));
      rst       <= 1'b1;
      awaddr    <= '0;
      awvalid   <= 1'b0;
      wdata     <= '0;
      wstrb     <= '0;
      wvalid    <= 1'b0;
      bready    <= 1'b0;
      araddr    <= '0;
      arvalid   <= 1'b0;
      rready    <= 1'b0;
      printDone <= 1'b0;
      online    <= 1'b1;
      vfuRdy    <= 1'b1;
      ovfu      <= 1'b0;
      printVal  <= 1'b0;
      printLpe  <= 1'b0;
      printDpar <= 1'b0;
      setMpe    <= 1'b0;
      setRpe    <= 1'b0;
      setMsyn   <= 1'b0;
      setDte    <= 1'b0;
      goModel   = 1'b0;
      modeModel = 2'b00;
      ieModel   = 1'b0;
      doneModel = 1'b0;
      testModel = 3'b000;
      mpeModel  = 1'b0;
      rpeModel  = 1'b0;
      goeModel  = 1'b0;
      msynModel = 1'b0;
      dteModel  = 1'b0;
      repeat (3)
         @(posedge clk);
      rst <= 1'b0;

      // Reset state
      @(negedge clk);
      checkValue(32'(irq), 32'd0, "irq after reset");
      axiRead(4'h0);
      axiRead(4'h4);

      // CSRA byte lanes
      repeat (20)
      begin
         axiWrite(4'h0, 16'($urandom), 4'($urandom));
         axiRead(4'h0);
      end

      // CSRB test field and live status
      repeat (12)
      begin
         axiWrite(4'h4, 16'($urandom), 4'($urandom));
         axiRead(4'h4);
         driveStatus(6'($urandom));
         axiRead(4'h4);
         axiRead(4'h0);
      end
      // Online, VFU ready, no LPE
      driveStatus(6'b000110);

      // Sticky errors, then ECLR
      repeat (20)
      begin
         pulseEvent(int'($urandom_range(4, 1)));
         if ($urandom_range(3) == 0)
            axiRead(4'h4);
      end
      axiRead(4'h0);
      axiWrite(4'h0, 16'h1000, 4'b0010);
      axiRead(4'h4);
      axiRead(4'h0);
      // More errors, TEST set, then INIT
      repeat (8)
         pulseEvent(int'($urandom_range(4, 1)));
      axiWrite(4'h4, 16'h0700, 4'b0010);
      axiWrite(4'h0, 16'h4000, 4'b0010);
      axiRead(4'h4);
      axiRead(4'h0);
      axiWrite(4'h0, 16'h1000, 4'b0010);
      axiRead(4'h4);

      // GO while offline gives GOE and an ERR interrupt
      driveStatus(6'b000010);
      axiWrite(4'h0, 16'h0041, 4'b0001);
      axiRead(4'h4);
      axiRead(4'h0);
      axiWrite(4'h0, 16'h4000, 4'b0010);
      driveStatus(6'b000110);
      // Online start in test mode, then printer done
      axiWrite(4'h0, 16'h0045, 4'b0001);
      axiRead(4'h0);
      pulseEvent(0);
      axiRead(4'h0);
      @(negedge clk);
      checkValue(32'(irq), 32'd1, "irq on DONE with IE");
      // New GO drops DONE
      axiWrite(4'h0, 16'h0041, 4'b0001);
      axiRead(4'h0);
      pulseEvent(0);
      axiRead(4'h0);

      // Unmapped addresses leave both registers alone
      axiWrite(4'h8, 16'($urandom), 4'hf);
      axiRead(4'h8);
      axiWrite(4'hc, 16'($urandom), 4'hf);
      axiRead(4'h2);
      axiRead(4'h0);
      axiRead(4'h4);

      $display("Simulation finished: PASS");
      $finish;
   end

endmodule
